/* logic/uart_pkg.sv */
//----------------------------------------------------------
// UART loopback shared definitions
// Serial timing, widths, byte events and link status
//----------------------------------------------------------

package uart_pkg;

  //----------------------------------------------------------
  // Serial timing
  //----------------------------------------------------------
  // Clock cycles per serial bit
  localparam int UART_CYCLES_PER_BIT = 4;
  // Extra stop bits so a receiver can resync between frames
  localparam int UART_EXTRA_STOP_BITS = 7;
  // Start + 8 data + stop + extra stops
  localparam int UART_FRAME_BITS = 10 + UART_EXTRA_STOP_BITS;
  localparam int UART_CYCLE_BITS = $clog2(UART_CYCLES_PER_BIT);
  localparam int UART_CURSOR_BITS = $clog2(UART_FRAME_BITS);
  // Receiver offset to the bit center
  localparam int UART_HALF_BIT = UART_CYCLES_PER_BIT / 2;

  //----------------------------------------------------------
  // Message and monitor sizing
  //----------------------------------------------------------
  localparam int MSG_LEN = 16;
  localparam int MON_QUEUE_DEPTH = 4;
  localparam int MON_PTR_BITS = $clog2(MON_QUEUE_DEPTH);
  // One extra bit so a full queue is representable
  localparam int MON_FILL_BITS = $clog2(MON_QUEUE_DEPTH + 1);

  typedef logic [7:0] uart_byte_t;
  typedef logic [3:0] msg_index_t;
  // Index plus a carry bit to hold MSG_LEN itself
  typedef logic [$bits(msg_index_t):0] msg_count_t;
  typedef logic [15:0] uart_sum_t;
  typedef logic [7:0] err_count_t;
  typedef logic [UART_CYCLE_BITS-1:0] bit_cycle_t;
  typedef logic [UART_CURSOR_BITS-1:0] bit_cursor_t;
  typedef logic [MON_PTR_BITS-1:0] mon_ptr_t;
  typedef logic [MON_FILL_BITS-1:0] mon_fill_t;

  // Byte sent or byte received with a one-cycle strobe
  typedef struct packed {
    logic       strobe;
    uart_byte_t data;
  } byte_event_t;

  typedef struct packed {
    logic       done;
    uart_sum_t  sum;
    msg_count_t count;
    err_count_t errors;
  } link_status_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

/* logic/message_source.sv */
//----------------------------------------------------------
// Message source
// Walks the stored message and feeds one byte into the
// transmitter on every clear-to-send after a start pulse
//----------------------------------------------------------
`timescale 1ns/100ps

module message_source (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_start,
  input  logic                  i_cts,
  output logic                  o_req,
  output uart_pkg::uart_byte_t  o_data,
  output uart_pkg::byte_event_t o_sent,
  output logic                  o_done
);

  // Message ROM
  uart_pkg::uart_byte_t msg_rom [uart_pkg::MSG_LEN];

  // Run control
  logic                 armed;
  uart_pkg::msg_index_t index;
  logic                 last_byte;

  initial begin
    $readmemh("logic/message.hex", msg_rom);
  end

  //----------------------------------------------------------
  // Request decode
  //----------------------------------------------------------
  // Only ask while the transmitter is clear to send
  assign o_req = armed && i_cts;
  assign o_data = msg_rom[index];

  // Sent event shares the request cycle
  assign o_sent = '{strobe: o_req, data: o_data};

  assign last_byte = (index == uart_pkg::msg_index_t'(uart_pkg::MSG_LEN - 1));

  //----------------------------------------------------------
  // Sequencer
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed <= 1'b0;
      index <= '0;
      o_done <= 1'b0;
    end else begin
      if (!armed) begin
        // Start is ignored mid-run
        if (i_start) begin
          armed <= 1'b1;
          index <= '0;
          o_done <= 1'b0;
        end
      end else if (o_req) begin
        // Transmitter leaves cts next cycle, so one byte per grant
        index <= index + 1'b1;
        if (last_byte) begin
          armed <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

endmodule

/* logic/uart_tx.sv */
//----------------------------------------------------------
// UART transmitter
// 8N1 frames, LSB first, plus extra stop bits for resync
//----------------------------------------------------------
`timescale 1ns/100ps

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_byte_t i_data,
  input  logic                 i_req,
  output logic                 o_serial,
  output logic                 o_cts,
  output logic                 o_idle
);

  // Cycles left in the current bit
  uart_pkg::bit_cycle_t  cycle;
  // Bits left in the frame, counts down to zero
  uart_pkg::bit_cursor_t cursor;
  // Start bit in [0], data above it, ones fill in from the top
  logic [8:0]            buffer;

  logic load;
  logic stop_done;

  //----------------------------------------------------------
  // Status decode
  //----------------------------------------------------------
  // Cursor at the first stop bit, in its final cycle
  assign stop_done =
    (cursor == uart_pkg::bit_cursor_t'(uart_pkg::UART_EXTRA_STOP_BITS)) && (cycle == '0);

  // Clear to send once the real stop bit is out
  assign o_cts = stop_done ||
    (cursor < uart_pkg::bit_cursor_t'(uart_pkg::UART_EXTRA_STOP_BITS));

  assign o_idle = (cursor == '0) && (cycle == '0);

  // Line is the low bit of the buffer
  assign o_serial = buffer[0];

  // Same condition the source sees, so a granted request always loads
  assign load = o_cts && i_req;

  //----------------------------------------------------------
  // Frame shifter
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle <= '0;
      cursor <= '0;
      // Line rests high
      buffer <= 9'h1FF;
    end else begin
      if (load) begin
        // New frame, may cut extra stop bits short
        cycle <= uart_pkg::bit_cycle_t'(uart_pkg::UART_CYCLES_PER_BIT - 1);
        cursor <= uart_pkg::bit_cursor_t'(uart_pkg::UART_FRAME_BITS - 1);
        buffer <= {i_data, 1'b0};
      end else if (cycle != '0) begin
        // Hold the bit
        cycle <= cycle - 1'b1;
      end else if (cursor != '0) begin
        // Next bit
        cycle <= uart_pkg::bit_cycle_t'(uart_pkg::UART_CYCLES_PER_BIT - 1);
        cursor <= cursor - 1'b1;
        buffer <= {1'b1, buffer[8:1]};
      end
    end
  end

endmodule

/* logic/uart_rx.sv */
//----------------------------------------------------------
// UART receiver
// Start-edge search, mid-bit sampling, stop-bit check;
// emits a one-cycle byte event on a good frame
//----------------------------------------------------------
`timescale 1ns/100ps

module uart_rx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_serial,
  output uart_pkg::byte_event_t o_rx
);

  // Synchronizer and edge history
  logic [1:0] sync_q;
  logic       line_prev;
  logic       rx_line;
  logic       fall;

  uart_pkg::rx_state_t  state;
  uart_pkg::bit_cycle_t cnt;
  logic [2:0]           bit_idx;
  uart_pkg::uart_byte_t shift_q;
  logic                 strobe_q;

  logic sample;

  assign rx_line = sync_q[1];
  assign fall = line_prev && !rx_line;

  // Bit center reached
  assign sample = (cnt == '0);

  assign o_rx = '{strobe: strobe_q, data: shift_q};

  //----------------------------------------------------------
  // Input synchronizer
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Idle line is high
      sync_q <= 2'b11;
      line_prev <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], i_serial};
      line_prev <= rx_line;
    end
  end

  //----------------------------------------------------------
  // Frame FSM
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::RX_IDLE;
      cnt <= '0;
      bit_idx <= '0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          // Falling edge marks a start bit
          if (fall) begin
            cnt <= uart_pkg::bit_cycle_t'(uart_pkg::UART_HALF_BIT - 1);
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (!sample) begin
            cnt <= cnt - 1'b1;
          end else if (!rx_line) begin
            // Start still low at its center
            cnt <= uart_pkg::bit_cycle_t'(uart_pkg::UART_CYCLES_PER_BIT - 1);
            bit_idx <= '0;
            state <= uart_pkg::RX_DATA;
          end else begin
            // Glitch
            state <= uart_pkg::RX_IDLE;
          end
        end
        uart_pkg::RX_DATA: begin
          if (!sample) begin
            cnt <= cnt - 1'b1;
          end else begin
            cnt <= uart_pkg::bit_cycle_t'(uart_pkg::UART_CYCLES_PER_BIT - 1);
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        uart_pkg::RX_STOP: begin
          if (!sample) begin
            cnt <= cnt - 1'b1;
          end else begin
            // Framing error drops the byte
            strobe_q <= rx_line;
            state <= uart_pkg::RX_IDLE;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if ((state == uart_pkg::RX_DATA) && sample) begin
      shift_q <= {rx_line, shift_q[7:1]};
    end
  end

endmodule

/* logic/link_monitor.sv */
//----------------------------------------------------------
// Link monitor
// Pairs received bytes with sent bytes, keeps sum, count
// and mismatch totals, flags the end of a run
//----------------------------------------------------------
`timescale 1ns/100ps

module link_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,
  input  uart_pkg::byte_event_t  i_sent,
  input  uart_pkg::byte_event_t  i_received,
  input  logic                   i_source_done,
  output uart_pkg::link_status_t o_status
);

  // Circular queue of bytes in flight
  uart_pkg::uart_byte_t queue_mem [uart_pkg::MON_QUEUE_DEPTH];
  uart_pkg::mon_ptr_t   wr_ptr;
  uart_pkg::mon_ptr_t   rd_ptr;
  uart_pkg::mon_fill_t  fill;

  logic                   running;
  uart_pkg::link_status_t status_q;

  logic q_empty;
  logic q_full;
  logic push;
  logic pop;
  logic mismatch;

  assign q_empty = (fill == '0);
  assign q_full = (fill == uart_pkg::mon_fill_t'(uart_pkg::MON_QUEUE_DEPTH));
  assign push = i_sent.strobe && !q_full;
  assign pop = i_received.strobe && !q_empty;

  // Unexpected byte counts as an error too
  assign mismatch = i_received.strobe &&
    (q_empty || (queue_mem[rd_ptr] != i_received.data));

  assign o_status = status_q;

  //----------------------------------------------------------
  // Sent-byte queue
  //----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      queue_mem[wr_ptr] <= i_sent.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  //----------------------------------------------------------
  // Run totals
  //----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      status_q <= '0;
    end else begin
      if (i_start && !running) begin
        // Fresh run, start during a run is ignored
        running <= 1'b1;
        status_q <= '0;
      end else begin
        if (i_received.strobe) begin
          status_q.sum <= status_q.sum + uart_pkg::uart_sum_t'(i_received.data);
          status_q.count <= status_q.count + 1'b1;
          status_q.errors <= status_q.errors + uart_pkg::err_count_t'(mismatch);
        end
        // Everything sent has come back
        if (running && i_source_done && q_empty) begin
          running <= 1'b0;
          status_q.done <= 1'b1;
        end
      end
    end
  end

endmodule

/* logic/uart_loopback_top.sv */
//----------------------------------------------------------
// UART loopback top
// Source and transmitter drive the serial line, which is
// looped into the receiver; the monitor checks the run
//----------------------------------------------------------
`timescale 1ns/100ps

module uart_loopback_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,
  output logic                   o_serial,
  output logic                   o_idle,
  output uart_pkg::byte_event_t  o_rx_event,
  output uart_pkg::link_status_t o_status
);

  // Source to transmitter
  logic                  tx_req;
  uart_pkg::uart_byte_t  tx_data;
  logic                  tx_cts;
  // Monitor feeds
  uart_pkg::byte_event_t sent_event;
  logic                  source_done;

  //----------------------------------------------------------
  // Transmit path
  //----------------------------------------------------------
  message_source u_source (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_start(i_start),
    .i_cts  (tx_cts),
    .o_req  (tx_req),
    .o_data (tx_data),
    .o_sent (sent_event),
    .o_done (source_done)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_data  (tx_data),
    .i_req   (tx_req),
    .o_serial(o_serial),
    .o_cts   (tx_cts),
    .o_idle  (o_idle)
  );

  //----------------------------------------------------------
  // Receive path, line looped back inside
  //----------------------------------------------------------
  uart_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_serial(o_serial),
    .o_rx    (o_rx_event)
  );

  link_monitor u_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_sent       (sent_event),
    .i_received   (o_rx_event),
    .i_source_done(source_done),
    .o_status     (o_status)
  );

endmodule

/* tests/tb_uart_loopback.sv */
//----------------------------------------------------------
// UART loopback testbench
// Runs the stored message through the looped serial line,
// decodes the line on its own and checks the link status
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_uart_loopback;

  // Bit period in clocks and message size
  localparam int CPB = 4;
  localparam int MSG_BYTES = 16;
  // Three runs of full frames plus reset, gaps and idle tails
  localparam int TIMEOUT_CYCLES = 3 * 16 * 17 * 4 + 600;

  logic clk;
  logic rst_n;
  logic i_start;

  logic                   o_serial;
  logic                   o_idle;
  uart_pkg::byte_event_t  o_rx_event;
  uart_pkg::link_status_t o_status;

  // Expected message and reference totals
  uart_pkg::uart_byte_t msg_exp [MSG_BYTES];
  uart_pkg::uart_sum_t  sum_exp;

  // Collected bytes of the current run
  uart_pkg::uart_byte_t rx_bytes [$];
  uart_pkg::uart_byte_t decoded [$];

  int seed;
  int cycle_count;
  int check_count;
  int error_count;
  int tests_run;

  uart_loopback_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_start   (i_start),
    .o_serial  (o_serial),
    .o_idle    (o_idle),
    .o_rx_event(o_rx_event),
    .o_status  (o_status)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //----------------------------------------------------------
  // Checking and reporting
  //----------------------------------------------------------
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  //----------------------------------------------------------
  // Line decoder sampling on the falling clock edge
  //----------------------------------------------------------
  task automatic decode_frame(output uart_pkg::uart_byte_t data);
    logic bit_val;
    int   b;
    // Hunt for the start edge
    @(negedge clk);
    while (o_serial !== 1'b0) @(negedge clk);
    // First start sample already seen
    repeat (CPB - 1) begin
      @(negedge clk);
      check_value(o_serial, 1'b0, "start bit held low");
    end
    // LSB first with each bit held a full period
    for (b = 0; b < 8; b++) begin
      @(negedge clk);
      bit_val = o_serial;
      repeat (CPB - 1) begin
        @(negedge clk);
        check_value(o_serial, bit_val, $sformatf("data bit %0d held", b));
      end
      data[b] = bit_val;
    end
    // At least one full stop bit before the next start
    repeat (CPB) begin
      @(negedge clk);
      check_value(o_serial, 1'b1, "stop bit high");
    end
  endtask

  initial begin
    uart_pkg::uart_byte_t frame_byte;
    wait (rst_n === 1'b1);
    forever begin
      decode_frame(frame_byte);
      decoded.push_back(frame_byte);
    end
  end

  // Received byte events
  always @(negedge clk) begin
    if (rst_n && o_rx_event.strobe === 1'b1) begin
      rx_bytes.push_back(o_rx_event.data);
    end
  end

  //----------------------------------------------------------
  // Run sequencing
  //----------------------------------------------------------
  task automatic run_message(input bit restart_mid_run);
    int gap;
    gap = {$random(seed)} % 16;
    rx_bytes.delete();
    decoded.delete();
    repeat (gap) @(posedge clk);
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    // Start has been taken on this edge
    @(negedge clk);
    check_value(o_status, 32'h0, "status cleared by start");
    if (restart_mid_run) begin
      // About halfway through the message
      repeat (MSG_BYTES / 2 * 10 * CPB) @(posedge clk);
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
    end
    @(negedge clk);
    while (!o_status.done) @(negedge clk);
    // Let the extra stop bits drain
    while (!o_idle) @(negedge clk);
  endtask

  task automatic check_run(input string tag);
    int i;
    check_value(rx_bytes.size(), MSG_BYTES, {tag, " received event count"});
    check_value(decoded.size(), MSG_BYTES, {tag, " decoded frame count"});
    for (i = 0; i < MSG_BYTES; i++) begin
      if (i < rx_bytes.size()) begin
        check_value(rx_bytes[i], msg_exp[i], $sformatf("%s received byte %0d", tag, i));
      end
      if (i < decoded.size()) begin
        check_value(decoded[i], msg_exp[i], $sformatf("%s decoded byte %0d", tag, i));
      end
    end
    check_value(o_status.done, 1'b1, {tag, " done"});
    check_value(o_status.sum, sum_exp, {tag, " sum"});
    check_value(o_status.count, MSG_BYTES, {tag, " count"});
    check_value(o_status.errors, 0, {tag, " errors"});
  endtask

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------
  task automatic test_reset_state();
    int errs_before;
    errs_before = error_count;
    @(negedge clk);
    check_value(o_serial, 1'b1, "serial line high after reset");
    check_value(o_idle, 1'b1, "transmitter idle after reset");
    check_value(o_rx_event.strobe, 1'b0, "no receive event after reset");
    check_value(o_status, 32'h0, "status zero after reset");
    report_test("reset state", errs_before);
  endtask

  task automatic test_first_run();
    int errs_before;
    errs_before = error_count;
    run_message(1'b0);
    check_run("first run");
    report_test("line timing and byte order", errs_before);
  endtask

  task automatic test_start_while_busy();
    int errs_before;
    errs_before = error_count;
    run_message(1'b1);
    check_run("busy start");
    report_test("start while busy", errs_before);
  endtask

  task automatic test_rerun();
    int errs_before;
    errs_before = error_count;
    run_message(1'b0);
    check_run("rerun");
    report_test("rerun", errs_before);
  endtask

  //----------------------------------------------------------
  // Timeout
  //----------------------------------------------------------
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
    $display("Errors found");
    $finish;
  end

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    int i;
    seed = 32'he7d;
    check_count = 0;
    error_count = 0;
    tests_run = 0;
    i_start = 1'b0;
    rst_n = 1'b0;
    $readmemh("logic/message.hex", msg_exp);
    // Reference sum wraps at 16 bits
    sum_exp = '0;
    for (i = 0; i < MSG_BYTES; i++) begin
      sum_exp = sum_exp + uart_pkg::uart_sum_t'(msg_exp[i]);
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_first_run();
    test_start_while_busy();
    test_rerun();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
             error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
logic/uart_pkg.sv
logic/message_source.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/link_monitor.sv
logic/uart_loopback_top.sv
tests/tb_uart_loopback.sv

/* Makefile */
# Verilator build and run for the UART loopback testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_uart_loopback
RTL_TOP   ?= uart_loopback_top
FILELIST  ?= build.f
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Simulation runs from the project root so the hex file path resolves
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* logic/message.hex */
// One message byte per line, hex, sent in file order
48
65
6C
6C
6F
2C
20
55
41
52
54
20
6C
6F
6F
70
